// ==== bench/axil_mem_model.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module axil_mem_model (
	input  logic                    clk,
	input  logic                    rst,
	input  axi_lite_pkg::axil_req_s bus_req,
	output axi_lite_pkg::axil_rsp_s bus_rsp,
	input  logic [2:0]              rand_delay,
	input  logic [1:0]              bus_mode,
	input  logic                    release_rsp
);
	import axi_lite_pkg::*;

	typedef enum logic [2:0] {PH_IDLE, PH_ADDR, PH_ACCEPT, PH_RESP, PH_HOLD, PH_OUT} phase_e;

	phase_e               phase;
	logic [2:0]           delay;
	logic                 is_wr;
	logic [`MEM_XLEN-1:0] mem [0:255];
	axil_resp_e           resp_code;

	assign resp_code = (bus_mode == 2'd1) ? SLVERR : OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase   <= PH_IDLE;
			delay   <= '0;
			is_wr   <= 1'b0;
			bus_rsp <= '0;
			for (int i = 0; i < 256; i++)
				mem[i] <= '0;
		end else begin
			bus_rsp.awready <= 1'b0;
			bus_rsp.wready  <= 1'b0;
			bus_rsp.arready <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if ((bus_req.awvalid && bus_req.wvalid) || bus_req.arvalid) begin
						is_wr <= bus_req.awvalid;
						delay <= rand_delay;
						phase <= PH_ADDR;
					end
				end
				PH_ADDR: begin
					if (delay != 0) begin
						delay <= delay - 1'b1;
					end else begin
						bus_rsp.awready <= is_wr;
						bus_rsp.wready  <= is_wr;
						bus_rsp.arready <= !is_wr;
						phase           <= PH_ACCEPT;
					end
				end
				PH_ACCEPT: begin // The master's handshake completes on this edge
					for (int b = 0; b < `MEM_XLEN/8; b++)
						if (is_wr && bus_mode != 2'd1 && bus_req.wstrb[b])
							mem[bus_req.awaddr[9:2]][8*b +: 8] <= bus_req.wdata[8*b +: 8];
					if (!is_wr)
						bus_rsp.rdata <= mem[bus_req.araddr[9:2]];
					delay <= rand_delay;
					phase <= PH_RESP;
				end
				PH_RESP, PH_HOLD: begin
					if (phase == PH_RESP && delay != 0) begin
						delay <= delay - 1'b1;
					end else if (bus_mode == 2'd2 && !release_rsp) begin
						phase <= PH_HOLD; // Sits here until the bench lets the response go
					end else begin
						bus_rsp.bvalid <= is_wr;
						bus_rsp.bresp  <= resp_code;
						bus_rsp.rvalid <= !is_wr;
						bus_rsp.rresp  <= resp_code;
						phase          <= PH_OUT;
					end
				end
				PH_OUT: begin
					if ((bus_rsp.bvalid && bus_req.bready) || (bus_rsp.rvalid && bus_req.rready)) begin
						bus_rsp.bvalid <= 1'b0;
						bus_rsp.rvalid <= 1'b0;
						phase          <= PH_IDLE;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

// ==== bench/mem_stage_tb.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage_tb;
	import rv_mem_pkg::*;
	import axi_lite_pkg::*;

	localparam int RESET_CYCLES = 10;

	typedef struct packed {
		ex_mem_s              rec;
		logic [1:0]           mode; // 0 normal, 1 SLVERR, 2 withheld response
		logic [`MEM_XLEN-1:0] exp_data;
		logic                 exp_fault;
	} test_s;

	logic       clk = 1'b0;
	logic       rst;
	logic       in_valid;
	logic       in_ready;
	ex_mem_s    in_rec;
	logic       out_valid;
	logic       out_ready;
	mem_wb_s    out_rec;
	axil_req_s  bus_req;
	axil_rsp_s  bus_rsp;
	logic [2:0] rand_delay;
	logic [1:0] bus_mode;
	logic       release_rsp;

	logic [31:0] lfsr;
	test_s       tests[$];
	mem_wb_s     results[$];
	mem_wb_s     held_rec;
	logic        held;
	ex_mem_s     cur;
	int          mismatches;
	int          failures;
	int          taken;
	int          valid_cycles;
	int          cycle_count;
	int          cycle_limit;

	mem_stage UUT (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready), .in_rec(in_rec),
		.out_valid(out_valid), .out_ready(out_ready), .out_rec(out_rec),
		.bus_req(bus_req), .bus_rsp(bus_rsp)
	);

	axil_mem_model u_mem (
		.clk(clk), .rst(rst), .bus_req(bus_req), .bus_rsp(bus_rsp),
		.rand_delay(rand_delay), .bus_mode(bus_mode), .release_rsp(release_rsp)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int count, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [3:0] store_strobe(input ex_mem_s rec);
		case (rec.mem_op)
			MEM_SB:  return 4'b0001 << rec.alu_out[1:0];
			MEM_SH:  return 4'b0011 << rec.alu_out[1:0];
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [31:0] replicated_wdata(input ex_mem_s rec);
		case (rec.mem_op)
			MEM_SB:  return {4{rec.rs2_data[7:0]}};
			MEM_SH:  return {2{rec.rs2_data[15:0]}};
			default: return rec.rs2_data;
		endcase
	endfunction

	function automatic logic access_misaligned(input ex_mem_s rec);
		case (rec.mem_op)
			MEM_LH, MEM_LHU, MEM_SH: return rec.alu_out[0];
			MEM_LW, MEM_SW:          return rec.alu_out[1:0] != 2'b00;
			default:                 return 1'b0;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		mismatches++;
		$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
	endtask

	initial begin
		forever #5 clk = ~clk;
	end

	initial begin : watchdog
		stage_state_e st;
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		st = UUT.u_fsm.state;
		failures++;
		$display("timeout after %0d cycles with the FSM in %s", cycle_count, st.name());
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// Bus lane checks, out_rec stability and the random out_ready all live on the falling edge
	always @(negedge clk) begin : bus_and_output_side
		logic [7:0] bits;
		if (bus_req.awvalid || bus_req.wvalid || bus_req.arvalid)
			valid_cycles++;
		if (bus_req.awvalid && bus_rsp.awready && bus_req.awaddr !== cur.alu_out)
			report_mismatch("awaddr", cur.alu_out, bus_req.awaddr);
		if (bus_req.wvalid && bus_rsp.wready && bus_req.wdata !== replicated_wdata(cur))
			report_mismatch("wdata", replicated_wdata(cur), bus_req.wdata);
		if (bus_req.wvalid && bus_rsp.wready && bus_req.wstrb !== store_strobe(cur))
			report_mismatch("wstrb", store_strobe(cur), bus_req.wstrb);
		if (bus_req.arvalid && bus_rsp.arready && bus_req.araddr !== cur.alu_out)
			report_mismatch("araddr", cur.alu_out, bus_req.araddr);
		if (out_valid && held && out_rec !== held_rec) begin
			mismatches++;
			$display("mismatch at %0t: out_rec expected %h got %h", $time, held_rec, out_rec);
		end
		if (held && !out_valid) begin
			failures++;
			$display("out_valid fell at %0t before its result was taken", $time);
		end
		draw_bits(3, bits);
		rand_delay = bits[2:0];
		draw_bits(1, bits);
		out_ready = bits[0];
		if (out_valid && out_ready) begin
			results.push_back(out_rec); // Taken on the coming rising edge
			taken++;
		end
		held     = out_valid && !out_ready;
		held_rec = out_rec;
	end

	initial begin : main
		int               fd;
		logic [8*128-1:0] line;
		logic [31:0]      pc, addr, rs2, data;
		logic [3:0]       op, wb;
		logic [1:0]       mode;
		logic             fault;
		test_s            t;
		mem_wb_s          res;
		int               seen;
		int               wait_cycles;
		logic             bad_align;

		rst         = 1'b1;
		in_valid    = 1'b0;
		in_rec      = '0;
		out_ready   = 1'b0;
		rand_delay  = '0;
		bus_mode    = '0;
		release_rsp = 1'b0;
		held        = 1'b0;
		cur         = '0;
		lfsr        = 32'hcc02;
		fd = $fopen("bench/mem_stage_tests.txt", "r");
		if (fd == 0) begin
			failures++;
			$display("could not open bench/mem_stage_tests.txt");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h",
					pc, addr, rs2, op, wb, mode, data, fault) == 8) begin
					t.rec.pc       = pc;
					t.rec.alu_out  = addr;
					t.rec.rs2_data = rs2;
					t.rec.mem_op   = mem_op_e'(op);
					t.rec.wb_sel   = wb;
					t.mode         = mode;
					t.exp_data     = data;
					t.exp_fault    = fault;
					tests.push_back(t);
				end
			end
			$fclose(fd);
		end
		if (tests.size() == 0) begin
			failures++;
			$display("no tests were read");
		end
		cycle_limit = tests.size() * (`MEM_BUS_TIMEOUT + 20) + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		if (!in_ready || out_valid || bus_req.awvalid || bus_req.wvalid || bus_req.arvalid
			|| bus_req.bready || bus_req.rready) begin
			failures++;
			$display("handshake outputs are not idle after reset");
		end
		rst = 1'b0;

		foreach (tests[i]) begin
			t         = tests[i];
			bad_align = access_misaligned(t.rec);
			@(negedge clk);
			cur      = t.rec;
			bus_mode = t.mode;
			seen     = valid_cycles;
			in_rec   = t.rec;
			in_valid = 1'b1;
			while (!in_ready)
				@(negedge clk);
			@(negedge clk); // Acceptance edge has passed
			in_valid = 1'b0;
			if (t.rec.mem_op == MEM_NONE && !out_valid) begin
				failures++;
				$display("test %0d: out_valid not up one edge after a pass-through record", i);
			end
			if (bad_align) begin
				if (out_valid) begin
					failures++;
					$display("test %0d: out_valid up too early for a misaligned access", i);
				end
				@(negedge clk);
				if (!out_valid) begin
					failures++;
					$display("test %0d: out_valid not up two edges after a misaligned access", i);
				end
			end
			wait_cycles = 0;
			@(posedge clk);
			while (results.size() == 0) begin
				@(posedge clk);
				wait_cycles++;
			end
			res = results.pop_front();
			if (res.pc !== t.rec.pc)
				report_mismatch("pc", t.rec.pc, res.pc);
			if (res.alu_out !== t.rec.alu_out)
				report_mismatch("alu_out", t.rec.alu_out, res.alu_out);
			if (res.wb_sel !== t.rec.wb_sel)
				report_mismatch("wb_sel", t.rec.wb_sel, res.wb_sel);
			if (res.read_data !== t.exp_data)
				report_mismatch("read_data", t.exp_data, res.read_data);
			if (res.fault !== t.exp_fault)
				report_mismatch("fault", t.exp_fault, res.fault);
			if (bad_align && valid_cycles != seen) begin
				failures++;
				$display("test %0d: a bus valid rose for a misaligned access", i);
			end
			if (t.mode == 2'd2) begin
				if (wait_cycles < `MEM_BUS_TIMEOUT) begin
					failures++;
					$display("test %0d: result came after %0d cycles, before the bus timeout",
						i, wait_cycles);
				end
				repeat (4) begin
					@(negedge clk);
					if (in_ready) begin
						failures++;
						$display("in_ready rose at %0t while the late response was withheld", $time);
					end
				end
				release_rsp = 1'b1;
				@(negedge clk);
				release_rsp = 1'b0;
				while (!in_ready)
					@(negedge clk);
			end
		end

		if (taken != tests.size()) begin
			failures++;
			$display("%0d results taken for %0d tests", taken, tests.size());
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== bench/mem_stage_tests.txt ====
# Columns in hex: pc addr rs2 op wb_sel bus_mode expected_read_data expected_fault
# op 0 none 1 lb 2 lh 3 lw 4 lbu 5 lhu 6 sb 7 sh 8 sw; bus_mode 0 okay 1 slverr 2 withheld
00001000 12345678 deadbeef 0 1 0 ffffffff 0
00001004 00000100 11223344 8 0 0 ffffffff 0
00001008 00000104 000000f1 6 0 0 ffffffff 0
0000100c 00000105 00000082 6 0 0 ffffffff 0
00001010 00000106 00000073 6 0 0 ffffffff 0
00001014 00000107 000000e4 6 0 0 ffffffff 0
00001018 00000108 0000a5c3 7 0 0 ffffffff 0
0000101c 0000010a 12347e01 7 0 0 ffffffff 0
00001020 00000100 00000000 3 2 0 11223344 0
00001024 00000104 00000000 1 3 0 fffffff1 0
00001028 00000105 00000000 4 4 0 00000082 0
0000102c 00000107 00000000 1 5 0 ffffffe4 0
00001030 00000108 00000000 2 6 0 ffffa5c3 0
00001034 00000108 00000000 5 7 0 0000a5c3 0
00001038 0000010a 00000000 2 8 0 00007e01 0
0000103c 00000104 00000000 3 9 0 e47382f1 0
00001040 00000100 00000000 3 a 1 00000000 1
00001044 00000101 00000000 2 b 0 00000000 1
00001048 00000102 55667788 8 c 0 00000000 1
0000104c 00000108 00000000 3 d 2 00000000 1
00001050 0000010b 00000000 4 e 0 0000007e 0
00002000 cafef00d 0badf00d 0 f 0 ffffffff 0

// ==== filelist.f ====
+incdir+include
rtl/rv_mem_pkg.sv
rtl/axi_lite_pkg.sv
rtl/bus_wait_timer.sv
rtl/load_store_align.sv
rtl/axil_data_port.sv
rtl/mem_stage_fsm.sv
rtl/mem_stage.sv
bench/axil_mem_model.sv
bench/mem_stage_tb.sv

// ==== include/mem_stage_settings.svh ====
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data and address width of the core and of the data bus
`define MEM_XLEN 32

// Cycles the stage waits for a bus response before it reports a fault
`define MEM_BUS_TIMEOUT 64

`endif

// ==== rtl/axi_lite_pkg.sv ====
`include "mem_stage_settings.svh"

package axi_lite_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axil_resp_e;

	// Everything the master drives
	typedef struct packed {
		logic [`MEM_XLEN-1:0]   awaddr;
		logic                   awvalid;
		logic [`MEM_XLEN-1:0]   wdata;
		logic [`MEM_XLEN/8-1:0] wstrb;
		logic                   wvalid;
		logic                   bready;
		logic [`MEM_XLEN-1:0]   araddr;
		logic                   arvalid;
		logic                   rready;
	} axil_req_s;

	// Everything the slave drives
	typedef struct packed {
		logic                 awready;
		logic                 wready;
		logic                 bvalid;
		axil_resp_e           bresp;
		logic                 arready;
		logic                 rvalid;
		logic [`MEM_XLEN-1:0] rdata;
		axil_resp_e           rresp;
	} axil_rsp_s;

endpackage

// ==== rtl/axil_data_port.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module axil_data_port (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  logic                     is_write,
	input  logic [`MEM_XLEN-1:0]     addr,
	input  logic [`MEM_XLEN-1:0]     wdata,
	input  logic [`MEM_XLEN/8-1:0]   wstrb,
	output logic                     done,
	output logic                     resp_err,
	output logic [`MEM_XLEN-1:0]     rdata,
	output logic                     busy,
	output axi_lite_pkg::axil_req_s  bus_req,
	input  axi_lite_pkg::axil_rsp_s  bus_rsp
);
	import axi_lite_pkg::*;

	logic                   aw_pend;
	logic                   w_pend;
	logic                   b_pend;
	logic                   ar_pend;
	logic                   r_pend;
	logic [`MEM_XLEN-1:0]   addr_q;
	logic [`MEM_XLEN-1:0]   wdata_q;
	logic [`MEM_XLEN/8-1:0] wstrb_q;
	logic                   aw_fire;
	logic                   w_fire;
	logic                   b_fire;
	logic                   ar_fire;
	logic                   r_fire;
	axil_resp_e             resp_code;

	assign aw_fire = aw_pend && bus_rsp.awready;
	assign w_fire  = w_pend && bus_rsp.wready;
	assign b_fire  = b_pend && bus_rsp.bvalid;
	assign ar_fire = ar_pend && bus_rsp.arready;
	assign r_fire  = r_pend && bus_rsp.rvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
			b_pend  <= 1'b0;
			ar_pend <= 1'b0;
			r_pend  <= 1'b0;
		end else begin
			if (start) begin
				aw_pend <= is_write;
				w_pend  <= is_write;
				ar_pend <= !is_write;
			end else begin
				if (aw_fire) aw_pend <= 1'b0;
				if (w_fire)  w_pend  <= 1'b0;
				if (ar_fire) ar_pend <= 1'b0;
			end
			// Address and data may be accepted in either order
			if ((aw_pend || w_pend) && (aw_fire || !aw_pend) && (w_fire || !w_pend))
				b_pend <= 1'b1;
			else if (b_fire)
				b_pend <= 1'b0;
			if (ar_fire)
				r_pend <= 1'b1;
			else if (r_fire)
				r_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q  <= addr;
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
	end

	// Still busy after a timeout, so a late response is taken here and dropped
	assign busy      = aw_pend || w_pend || b_pend || ar_pend || r_pend;
	assign done      = b_fire || r_fire;
	assign resp_code = b_pend ? bus_rsp.bresp : bus_rsp.rresp;
	assign resp_err  = done && (resp_code != OKAY);
	assign rdata     = bus_rsp.rdata;

	assign bus_req.awaddr  = addr_q;
	assign bus_req.awvalid = aw_pend;
	assign bus_req.wdata   = wdata_q;
	assign bus_req.wstrb   = wstrb_q;
	assign bus_req.wvalid  = w_pend;
	assign bus_req.bready  = b_pend;
	assign bus_req.araddr  = addr_q;
	assign bus_req.arvalid = ar_pend;
	assign bus_req.rready  = r_pend;

endmodule

// ==== rtl/bus_wait_timer.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module bus_wait_timer (
	input  logic clk,
	input  logic rst,
	input  logic wait_active,
	output logic expired
);
	localparam int CNT_W = $clog2(`MEM_BUS_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`MEM_BUS_TIMEOUT);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst || !wait_active)
			count <= '0; // Each access starts its own window
		else if (count != LIMIT)
			count <= count + 1'b1;
	end

	// The count lags one cycle behind a falling wait_active
	assign expired = wait_active && (count == LIMIT);

endmodule

// ==== rtl/load_store_align.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module load_store_align (
	input  rv_mem_pkg::ex_mem_s    rec,
	input  logic [`MEM_XLEN-1:0]   rdata,
	output logic [`MEM_XLEN-1:0]   store_word,
	output logic [`MEM_XLEN/8-1:0] store_strb,
	output logic                   misaligned,
	output logic [`MEM_XLEN-1:0]   load_value
);
	import rv_mem_pkg::*;

	localparam int STRB_W = `MEM_XLEN / 8;
	localparam int OFF_W  = $clog2(STRB_W);

	logic [OFF_W-1:0]     offset;
	logic [`MEM_XLEN-1:0] shifted;

	assign offset  = rec.alu_out[OFF_W-1:0];
	assign shifted = rdata >> {offset, 3'b000}; // Addressed lane moves down to bit 0

	always_comb begin
		case (rec.mem_op)
			MEM_SB: begin
				store_word = {STRB_W{rec.rs2_data[7:0]}};
				store_strb = STRB_W'(1) << offset;
			end
			MEM_SH: begin
				store_word = {(STRB_W/2){rec.rs2_data[15:0]}};
				store_strb = STRB_W'(3) << offset;
			end
			MEM_SW: begin
				store_word = rec.rs2_data;
				store_strb = '1;
			end
			default: begin
				store_word = rec.rs2_data;
				store_strb = '0;
			end
		endcase
	end

	always_comb begin
		case (rec.mem_op)
			MEM_LH, MEM_LHU, MEM_SH: misaligned = offset[0];
			MEM_LW, MEM_SW:          misaligned = (offset != '0);
			default:                 misaligned = 1'b0;
		endcase
	end

	always_comb begin
		case (rec.mem_op)
			MEM_LB:  load_value = {{(`MEM_XLEN-8){shifted[7]}}, shifted[7:0]};
			MEM_LBU: load_value = {{(`MEM_XLEN-8){1'b0}}, shifted[7:0]};
			MEM_LH:  load_value = {{(`MEM_XLEN-16){shifted[15]}}, shifted[15:0]};
			MEM_LHU: load_value = {{(`MEM_XLEN-16){1'b0}}, shifted[15:0]};
			default: load_value = rdata; // Whole word for LW
		endcase
	end

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  rv_mem_pkg::ex_mem_s     in_rec,
	output logic                    out_valid,
	input  logic                    out_ready,
	output rv_mem_pkg::mem_wb_s     out_rec,
	output axi_lite_pkg::axil_req_s bus_req,
	input  axi_lite_pkg::axil_rsp_s bus_rsp
);
	import rv_mem_pkg::*;

	ex_mem_s                cur_rec;
	logic [`MEM_XLEN-1:0]   store_word;
	logic [`MEM_XLEN/8-1:0] store_strb;
	logic                   misaligned;
	logic [`MEM_XLEN-1:0]   load_value;
	logic                   start;
	logic                   is_write;
	logic [`MEM_XLEN-1:0]   addr;
	logic [`MEM_XLEN-1:0]   wdata;
	logic [`MEM_XLEN/8-1:0] wstrb;
	logic                   done;
	logic                   resp_err;
	logic [`MEM_XLEN-1:0]   rdata;
	logic                   busy;
	logic                   wait_active;
	logic                   expired;

	mem_stage_fsm u_fsm (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready), .in_rec(in_rec),
		.out_valid(out_valid), .out_ready(out_ready), .out_rec(out_rec),
		.store_word(store_word), .store_strb(store_strb),
		.misaligned(misaligned), .load_value(load_value),
		.start(start), .is_write(is_write), .addr(addr), .wdata(wdata), .wstrb(wstrb),
		.done(done), .resp_err(resp_err), .busy(busy),
		.wait_active(wait_active), .expired(expired),
		.cur_rec(cur_rec)
	);

	bus_wait_timer u_timer (
		.clk(clk), .rst(rst),
		.wait_active(wait_active),
		.expired(expired)
	);

	load_store_align u_align (
		.rec(cur_rec), .rdata(rdata),
		.store_word(store_word), .store_strb(store_strb),
		.misaligned(misaligned), .load_value(load_value)
	);

	axil_data_port u_port (
		.clk(clk), .rst(rst),
		.start(start), .is_write(is_write), .addr(addr), .wdata(wdata), .wstrb(wstrb),
		.done(done), .resp_err(resp_err), .rdata(rdata), .busy(busy),
		.bus_req(bus_req), .bus_rsp(bus_rsp)
	);

endmodule

// ==== rtl/mem_stage_fsm.sv ====
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage_fsm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  rv_mem_pkg::ex_mem_s    in_rec,
	output logic                   out_valid,
	input  logic                   out_ready,
	output rv_mem_pkg::mem_wb_s    out_rec,
	input  logic [`MEM_XLEN-1:0]   store_word,
	input  logic [`MEM_XLEN/8-1:0] store_strb,
	input  logic                   misaligned,
	input  logic [`MEM_XLEN-1:0]   load_value,
	output logic                   start,
	output logic                   is_write,
	output logic [`MEM_XLEN-1:0]   addr,
	output logic [`MEM_XLEN-1:0]   wdata,
	output logic [`MEM_XLEN/8-1:0] wstrb,
	input  logic                   done,
	input  logic                   resp_err,
	input  logic                   busy,
	output logic                   wait_active,
	input  logic                   expired,
	output rv_mem_pkg::ex_mem_s    cur_rec
);
	import rv_mem_pkg::*;

	stage_state_e state;
	ex_mem_s      held_rec;
	logic         accept;
	logic         is_mem;
	logic         is_store;
	logic         bus_fault;

	function automatic mem_wb_s make_result(ex_mem_s rec, logic [`MEM_XLEN-1:0] data,
		logic fault);
		mem_wb_s res;
		res.pc        = rec.pc;
		res.alu_out   = rec.alu_out;
		res.read_data = data;
		res.wb_sel    = rec.wb_sel;
		res.fault     = fault;
		return res;
	endfunction

	assign in_ready = (state == ST_IDLE);
	assign accept   = in_valid && in_ready;

	// While idle the align logic looks at the incoming record, so the bus request
	// can be registered on the acceptance edge
	assign cur_rec  = (state == ST_IDLE) ? in_rec : held_rec;
	assign is_mem   = (cur_rec.mem_op != MEM_NONE);
	assign is_store = cur_rec.mem_op inside {MEM_SB, MEM_SH, MEM_SW};

	assign start       = accept && is_mem && !misaligned;
	assign is_write    = is_store;
	assign addr        = cur_rec.alu_out;
	assign wdata       = store_word;
	assign wstrb       = store_strb;
	assign wait_active = (state == ST_WAIT);
	assign out_valid   = (state == ST_DONE);
	assign bus_fault   = !done || resp_err; // No done while waiting means the timer ran out

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept)
						state <= is_mem ? ST_ISSUE : ST_DONE;
				end
				ST_ISSUE: state <= misaligned ? ST_DONE : ST_WAIT;
				ST_WAIT: begin
					if (done || expired)
						state <= ST_DONE;
				end
				ST_DONE: begin
					if (out_ready)
						state <= busy ? ST_DRAIN : ST_IDLE; // Port busy here only after a timeout
				end
				ST_DRAIN: begin
					if (!busy)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			held_rec <= in_rec;

		if (accept && !is_mem)
			out_rec <= make_result(in_rec, '1, 1'b0);
		else if (state == ST_ISSUE && misaligned)
			out_rec <= make_result(held_rec, '0, 1'b1);
		else if (state == ST_WAIT && (done || expired)) begin
			if (bus_fault)
				out_rec <= make_result(held_rec, '0, 1'b1);
			else
				out_rec <= make_result(held_rec, is_store ? '1 : load_value, 1'b0);
		end
	end

endmodule

// ==== rtl/rv_mem_pkg.sv ====
`include "mem_stage_settings.svh"

package rv_mem_pkg;

	typedef enum logic [3:0] {
		MEM_NONE = 4'd0, // Not a memory instruction
		MEM_LB   = 4'd1,
		MEM_LH   = 4'd2,
		MEM_LW   = 4'd3,
		MEM_LBU  = 4'd4,
		MEM_LHU  = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} mem_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT,
		ST_DONE,
		ST_DRAIN // A timed out access still has a response on its way
	} stage_state_e;

	// Record handed over by the execute stage
	typedef struct packed {
		logic [`MEM_XLEN-1:0] pc;
		logic [`MEM_XLEN-1:0] alu_out; // Effective address for loads and stores
		logic [`MEM_XLEN-1:0] rs2_data;
		mem_op_e              mem_op;
		logic [3:0]           wb_sel;
	} ex_mem_s;

	// Record handed on to write-back
	typedef struct packed {
		logic [`MEM_XLEN-1:0] pc;
		logic [`MEM_XLEN-1:0] alu_out;
		logic [`MEM_XLEN-1:0] read_data;
		logic [3:0]           wb_sel;
		logic                 fault;
	} mem_wb_s;

endpackage
